/* design/bus_strobe.sv */
// z80 i/o write sampler
// zpos-gated sampling of iorq_n/wr_n, one-cycle write strobe with captured address and data

`timescale 1ns/1ps

module bus_strobe (
	input  logic                 fclk,
	input  logic                 rst_n,
	input  logic                 zpos,    // z80 rising edge marker
	input  logic                 iorq_n,
	input  logic                 wr_n,
	input  zport_pkg::port_addr_t a,
	input  zport_pkg::zbyte_t     din,
	output logic                 wr_stb,  // one fclk per bus write
	output zport_pkg::port_addr_t s_addr,
	output zport_pkg::zbyte_t     s_data
);

	import zport_pkg::*;

	logic wr_act;   // write cycle seen on bus right now
	logic wr_lvl;   // zpos sample of wr_act
	logic wr_lvl_d; // previous fclk copy

	assign wr_act = ~(iorq_n | wr_n);

	always_ff @(posedge fclk or negedge rst_n)
	begin
		if (!rst_n)
		begin
			wr_lvl   <= 1'b0;
			wr_lvl_d <= 1'b0;
		end
		else
		begin
			if (zpos)
				wr_lvl <= wr_act; // only on z80 edges
			wr_lvl_d <= wr_lvl;
		end
	end

	// rising edge of the sampled level
	assign wr_stb = wr_lvl & ~wr_lvl_d;

	// first active sample grabs the bus, held until the next write
	always_ff @(posedge fclk)
	begin
		if (zpos && wr_act && !wr_lvl)
		begin
			s_addr <= a;
			s_data <= din;
		end
	end

	// a write cycle must never yield back-to-back strobes
	a_single_stb: assert property (@(posedge fclk) disable iff (!rst_n)
		wr_stb |=> !wr_stb);

endmodule

/* design/config_regs.sv */
// border, config port and ulaplus state
// xxFE/xxF6 border, xxBF config, xxBE nmi clear, xx3B ulaplus mode and palette

`timescale 1ns/1ps

module config_regs (
	input  logic                  fclk,
	input  logic                  rst_n,
	input  zport_pkg::port_sel_t  sel,
	input  zport_pkg::port_addr_t d_addr,
	input  zport_pkg::zbyte_t     d_data,
	input  logic                  dos,
	output logic                  shadow,
	output zport_pkg::border_t    border,
	output logic                  romrw_en,   // xxBF bit1
	output logic                  set_nmi,    // xxBF bit3
	output logic                  clr_nmi,
	output logic                  beeper_wr,
	output zport_pkg::zbyte_t     cfg_bits,
	output logic                  up_ena,
	output zport_pkg::up_addr_t   up_paladdr,
	output zport_pkg::zbyte_t     up_paldata,
	output logic                  up_palwr,
	output zport_pkg::zbyte_t     up_lastwritten
);

	import zport_pkg::*;

	logic      shadow_en; // xxBF bit0
	logic      fntw_en;   // xxBF bit2, kept for readback
	ula_mode_t up_state;

	assign shadow   = dos | shadow_en;
	assign cfg_bits = {4'b0000, set_nmi, fntw_en, romrw_en, shadow_en};

	//////////////////////////////////////////////////
	// border and xxBF

	always_ff @(posedge fclk or negedge rst_n)
	begin
		if (!rst_n)
		begin
			border    <= border_rst;
			shadow_en <= 1'b0;
			romrw_en  <= 1'b0;
			fntw_en   <= 1'b0;
			set_nmi   <= 1'b0;
		end
		else
		begin
			if (sel == sel_border || sel == sel_beeper_border)
				border <= {~d_addr[3], d_data[2:0]}; // f6 sets bit3, fe clears it
			if (sel == sel_config)
			begin
				shadow_en <= d_data[0];
				romrw_en  <= d_data[1];
				fntw_en   <= d_data[2];
				set_nmi   <= d_data[3];
			end
		end
	end

	//////////////////////////////////////////////////
	// strobes, one cycle after sel

	always_ff @(posedge fclk or negedge rst_n)
	begin
		if (!rst_n)
		begin
			clr_nmi   <= 1'b0;
			beeper_wr <= 1'b0;
			up_palwr  <= 1'b0;
		end
		else
		begin
			clr_nmi   <= (sel == sel_nmi_clr);
			beeper_wr <= (sel == sel_beeper_border); // fe only
			up_palwr  <= (sel == sel_up_data) && (up_state == up_group);
		end
	end

	//////////////////////////////////////////////////
	// ulaplus

	always_ff @(posedge fclk or negedge rst_n)
	begin
		if (!rst_n)
		begin
			up_state <= up_group;
			up_ena   <= 1'b0;
		end
		else
		begin
			if (sel == sel_up_reg)
			begin
				if (d_data[7:6] == 2'b01)
					up_state <= up_mode;
				else if (d_data[7:6] == 2'b00)
					up_state <= up_group;
			end
			if (sel == sel_up_data && up_state == up_mode)
				up_ena <= d_data[0];
		end
	end

	// palette address and last data byte
	always_ff @(posedge fclk)
	begin
		if (sel == sel_up_reg && d_data[7:6] == 2'b00)
			up_paladdr <= d_data[5:0];
		if (sel == sel_up_data)
			up_lastwritten <= d_data;
	end

	// G3R3B2 -> R3G3B2
	assign up_paldata = {up_lastwritten[4:2], up_lastwritten[7:5], up_lastwritten[1:0]};

endmodule

/* design/paging_regs.sv */
// memory paging registers 7FFD and EFF7
// 48K lock under 1M mode, gated views and pentagon-1M page outputs

`timescale 1ns/1ps

module paging_regs (
	input  logic                 fclk,
	input  logic                 rst_n,
	input  zport_pkg::port_sel_t sel,
	input  zport_pkg::zbyte_t    d_data,
	output zport_pkg::zbyte_t    p7ffd,         // gated by 1M block
	output zport_pkg::zbyte_t    peff7,         // gated by 1M block
	output zport_pkg::page_t     pent1m_page,
	output logic                 pent1m_rom,    // 7ffd bit4
	output logic                 pent1m_1m_on,
	output logic                 pent1m_ram0_0, // eff7 bit3
	output zport_pkg::zbyte_t    p7ffd_raw,
	output zport_pkg::zbyte_t    peff7_raw
);

	import zport_pkg::*;

	zbyte_t p7ffd_r;
	zbyte_t peff7_r;
	logic   block1m;   // eff7 bit2
	logic   lock48;    // 7ffd bit5 while block1m

	assign block1m = peff7_r[2];
	assign lock48  = p7ffd_r[5] & block1m;

	//////////////////////////////////////////////////
	// register writes

	always_ff @(posedge fclk or negedge rst_n)
	begin
		if (!rst_n)
		begin
			p7ffd_r <= p7ffd_rst;
			peff7_r <= peff7_rst;
		end
		else
		begin
			if (sel == sel_7ffd && !lock48)
				p7ffd_r <= d_data; // 2..0 page, 3 screen, 4 rom, 5 lock, 7..6 hi page
			if (sel == sel_eff7)
				peff7_r <= d_data;
		end
	end

	//////////////////////////////////////////////////
	// outputs

	// high page bits hidden while 1M is blocked
	assign p7ffd = {(block1m ? 3'b000 : p7ffd_r[7:5]), p7ffd_r[4:0]};

	assign peff7 = block1m ?
		{peff7_r[7], 1'b0, peff7_r[5:4], 3'b000, peff7_r[0]} :
		peff7_r;

	assign pent1m_page   = {p7ffd_r[7:5], p7ffd_r[2:0]};
	assign pent1m_rom    = p7ffd_r[4];
	assign pent1m_1m_on  = ~peff7_r[2];
	assign pent1m_ram0_0 = peff7_r[3];

	assign p7ffd_raw = p7ffd_r;
	assign peff7_raw = peff7_r;

	// locked 7ffd does not move on a write
	a_lock_holds: assert property (@(posedge fclk) disable iff (!rst_n)
		(sel == sel_7ffd && lock48) |=> $stable(p7ffd_raw));

endmodule

/* design/port_decode.sv */
// port address decoder
// registers the write target of a strobed bus write, low byte decode with shadow mode rules

`timescale 1ns/1ps

module port_decode (
	input  logic                  fclk,
	input  logic                  rst_n,
	input  logic                  wr_stb,
	input  zport_pkg::port_addr_t s_addr,
	input  zport_pkg::zbyte_t     s_data,
	input  logic                  shadow,  // dos or xxBF bit0
	output zport_pkg::port_sel_t  sel,
	output zport_pkg::port_addr_t d_addr,
	output zport_pkg::zbyte_t     d_data
);

	import zport_pkg::*;

	port_sel_t sel_nxt;

	//////////////////////////////////////////////////
	// low byte decode

	always_comb
	begin
		sel_nxt = sel_none;
		case (s_addr[7:0])
			port_fe:
				sel_nxt = sel_beeper_border;
			port_f6:
				sel_nxt = sel_border; // no beeper here
			port_fd:
				if (!s_addr[15])
					sel_nxt = sel_7ffd; // bffd/fffd belong to the ay
			port_f7:
				// eff7 gone in shadow mode, a12 keeps it off dff7
				if (s_addr[8] && !s_addr[12] && !shadow)
					sel_nxt = sel_eff7;
			port_bf:
				sel_nxt = sel_config;
			port_be:
				sel_nxt = sel_nmi_clr;
			port_ulaplus:
				sel_nxt = s_addr[14] ? sel_up_data : sel_up_reg;
			default:
				sel_nxt = sel_none;
		endcase
	end

	//////////////////////////////////////////////////
	// decode stage register

	always_ff @(posedge fclk or negedge rst_n)
	begin
		if (!rst_n)
			sel <= sel_none;
		else if (wr_stb)
			sel <= sel_nxt;
		else
			sel <= sel_none; // valid for one cycle only
	end

	always_ff @(posedge fclk)
	begin
		if (wr_stb)
		begin
			d_addr <= s_addr;
			d_data <= s_data;
		end
	end

endmodule

/* design/read_mux.sv */
// i/o read path
// port hit, data-out enable and read data, xxBE readback by a[12:8]

`timescale 1ns/1ps

module read_mux (
	input  zport_pkg::port_addr_t a,
	input  logic                  iorq_n,
	input  logic                  rd_n,
	input  logic                  shadow,
	input  logic [4:0]            keys_in,   // active low keys
	input  logic                  tape_read,
	input  zport_pkg::zbyte_t     cfg_bits,
	input  zport_pkg::zbyte_t     p7ffd_raw,
	input  zport_pkg::zbyte_t     peff7_raw,
	input  zport_pkg::border_t    border,
	input  zport_pkg::zbyte_t     up_lastwritten,
	output zport_pkg::zbyte_t     dout,
	output logic                  porthit,
	output logic                  dataout
);

	import zport_pkg::*;

	zbyte_t loa;     // low address byte
	zbyte_t be_mux;  // xxBE readback

	assign loa = a[7:0];

	//////////////////////////////////////////////////
	// hit and bus drive

	always_comb
	begin
		case (loa)
			port_fe, port_f6, port_fd, port_bf, port_be, port_ulaplus:
				porthit = 1'b1;
			port_f7:
				porthit = !shadow; // f7 is ours only outside dos
			default:
				porthit = 1'b0;
		endcase
	end

	assign dataout = porthit & ~iorq_n & ~rd_n;

	//////////////////////////////////////////////////
	// read data

	always_comb
	begin
		case (a[12:8])
			rb_7ffd:   be_mux = p7ffd_raw;
			rb_eff7:   be_mux = peff7_raw;
			rb_border: be_mux = {4'b0000, border};
			default:   be_mux = 8'hFF;
		endcase
	end

	always_comb
	begin
		case (loa)
			port_fe, port_f6:
				dout = {1'b1, tape_read, 1'b0, keys_in};
			port_bf:
				dout = cfg_bits;
			port_be:
				dout = be_mux;
			port_ulaplus:
				dout = up_lastwritten;
			default:
				dout = 8'hFF; // floating bus look
		endcase
	end

endmodule

/* design/zport_pkg.sv */
// shared types and constants for the z80 port block
// port map low bytes, readback indices, reset values

package zport_pkg;

	//////////////////////////////////////////////////
	// bus and register widths

	typedef logic [7:0]  zbyte_t;     // one z80 data byte
	typedef logic [15:0] port_addr_t; // full i/o address
	typedef logic [3:0]  border_t;    // ~a3 + 3 colour bits
	typedef logic [5:0]  page_t;      // 1M page, 7ffd[7:5],[2:0]
	typedef logic [5:0]  up_addr_t;   // ulaplus palette entry

	// decoded write target, one per port function
	typedef enum logic [3:0] {
		sel_none,
		sel_border,        // xxF6, border only
		sel_beeper_border, // xxFE, border plus beeper
		sel_7ffd,
		sel_eff7,
		sel_config,        // xxBF
		sel_nmi_clr,       // xxBE
		sel_up_reg,        // xx3B, a14 low
		sel_up_data        // xx3B, a14 high
	} port_sel_t;

	// what a ulaplus data write means
	typedef enum logic {
		up_group,  // palette write
		up_mode    // mode write, bit0 -> up_ena
	} ula_mode_t;

	//////////////////////////////////////////////////
	// port low bytes

	localparam zbyte_t port_fe      = 8'hFE;
	localparam zbyte_t port_f6      = 8'hF6;
	localparam zbyte_t port_fd      = 8'hFD;
	localparam zbyte_t port_f7      = 8'hF7;
	localparam zbyte_t port_bf      = 8'hBF;
	localparam zbyte_t port_be      = 8'hBE;
	localparam zbyte_t port_ulaplus = 8'h3B;

	// xxBE readback index, taken from a[12:8]
	localparam logic [4:0] rb_7ffd   = 5'hA;
	localparam logic [4:0] rb_eff7   = 5'hB;
	localparam logic [4:0] rb_border = 5'hF;

	// register values after reset
	localparam zbyte_t  p7ffd_rst  = 8'h00;
	localparam zbyte_t  peff7_rst  = 8'h00;
	localparam border_t border_rst = 4'h0;

endpackage

/* design/zports_top.sv */
// z80 i/o port block top
// strobe, decode and register stages plus the combinational read path

`timescale 1ns/1ps

module zports_top (
	input  logic                  fclk,
	input  logic                  rst_n,
	input  logic                  zpos,
	input  zport_pkg::port_addr_t a,
	input  zport_pkg::zbyte_t     din,
	input  logic                  iorq_n,
	input  logic                  rd_n,
	input  logic                  wr_n,
	input  logic                  dos,
	input  logic [4:0]            keys_in,
	input  logic                  tape_read,
	output zport_pkg::zbyte_t     dout,
	output logic                  porthit,
	output logic                  dataout,
	output zport_pkg::zbyte_t     p7ffd,
	output zport_pkg::zbyte_t     peff7,
	output zport_pkg::page_t      pent1m_page,
	output logic                  pent1m_rom,
	output logic                  pent1m_1m_on,
	output logic                  pent1m_ram0_0,
	output zport_pkg::border_t    border,
	output logic                  romrw_en,
	output logic                  set_nmi,
	output logic                  clr_nmi,
	output logic                  beeper_wr,
	output logic                  up_ena,
	output zport_pkg::up_addr_t   up_paladdr,
	output zport_pkg::zbyte_t     up_paldata,
	output logic                  up_palwr
);

	import zport_pkg::*;

	// stage 1 -> 2
	logic       wr_stb;
	port_addr_t s_addr;
	zbyte_t     s_data;
	// stage 2 -> 3
	port_sel_t  sel;
	port_addr_t d_addr;
	zbyte_t     d_data;
	// register state to the read path
	logic       shadow;
	zbyte_t     cfg_bits;
	zbyte_t     p7ffd_raw;
	zbyte_t     peff7_raw;
	zbyte_t     up_lastwritten;

	bus_strobe u_strobe (
		.fclk   (fclk),
		.rst_n  (rst_n),
		.zpos   (zpos),
		.iorq_n (iorq_n),
		.wr_n   (wr_n),
		.a      (a),
		.din    (din),
		.wr_stb (wr_stb),
		.s_addr (s_addr),
		.s_data (s_data)
	);

	port_decode u_decode (
		.fclk   (fclk),
		.rst_n  (rst_n),
		.wr_stb (wr_stb),
		.s_addr (s_addr),
		.s_data (s_data),
		.shadow (shadow),
		.sel    (sel),
		.d_addr (d_addr),
		.d_data (d_data)
	);

	paging_regs u_paging (
		.fclk          (fclk),
		.rst_n         (rst_n),
		.sel           (sel),
		.d_data        (d_data),
		.p7ffd         (p7ffd),
		.peff7         (peff7),
		.pent1m_page   (pent1m_page),
		.pent1m_rom    (pent1m_rom),
		.pent1m_1m_on  (pent1m_1m_on),
		.pent1m_ram0_0 (pent1m_ram0_0),
		.p7ffd_raw     (p7ffd_raw),
		.peff7_raw     (peff7_raw)
	);

	config_regs u_config (
		.fclk           (fclk),
		.rst_n          (rst_n),
		.sel            (sel),
		.d_addr         (d_addr),
		.d_data         (d_data),
		.dos            (dos),
		.shadow         (shadow),
		.border         (border),
		.romrw_en       (romrw_en),
		.set_nmi        (set_nmi),
		.clr_nmi        (clr_nmi),
		.beeper_wr      (beeper_wr),
		.cfg_bits       (cfg_bits),
		.up_ena         (up_ena),
		.up_paladdr     (up_paladdr),
		.up_paldata     (up_paldata),
		.up_palwr       (up_palwr),
		.up_lastwritten (up_lastwritten)
	);

	read_mux u_read (
		.a              (a),
		.iorq_n         (iorq_n),
		.rd_n           (rd_n),
		.shadow         (shadow),
		.keys_in        (keys_in),
		.tape_read      (tape_read),
		.cfg_bits       (cfg_bits),
		.p7ffd_raw      (p7ffd_raw),
		.peff7_raw      (peff7_raw),
		.border         (border),
		.up_lastwritten (up_lastwritten),
		.dout           (dout),
		.porthit        (porthit),
		.dataout        (dataout)
	);

endmodule

/* files.f */
+incdir+verification
design/zport_pkg.sv
design/bus_strobe.sv
design/port_decode.sv
design/paging_regs.sv
design/config_regs.sv
design/read_mux.sv
design/zports_top.sv
verification/tb_zports.sv

/* run_sim.sh */
#!/usr/bin/env bash
# build and run tb_zports with verilator, pass only if the log holds the pass line
cd "$(dirname "$0")" || exit 1
rm -f build.log sim.log
verilator --binary --timing --assert --top-module tb_zports -f files.f \
	-o tb_zports_sim > build.log 2>&1 \
	&& ./obj_dir/tb_zports_sim > sim.log 2>&1 \
	|| { cat build.log sim.log 2>/dev/null; echo "simulation did not complete"; exit 1; }
cat sim.log
grep -qx "Test OK" sim.log && echo "PASS" || { echo "FAIL"; exit 1; }

/* verification/tb_bus_tasks.svh */
// z80 bus cycle tasks for the port block testbench
// i/o write and read cycles, galois lfsr step

`ifndef TB_BUS_TASKS_SVH
`define TB_BUS_TASKS_SVH

// 32 bit galois lfsr, taps 32 22 2 1
function automatic logic [31:0] lfsr_next(input logic [31:0] s);
	if (s[0])
		return (s >> 1) ^ 32'h80200003;
	else
		return s >> 1;
endfunction

// i/o write, 12 cycles active then 8 idle
task automatic write_port(input logic [15:0] addr, input logic [7:0] data);
	@(posedge fclk);
	a      <= addr;
	din    <= data;
	iorq_n <= 1'b0;
	wr_n   <= 1'b0;
	repeat (12) @(posedge fclk); // spans at least two zpos samples
	iorq_n <= 1'b1;
	wr_n   <= 1'b1;
	repeat (8) @(posedge fclk);
endtask

// i/o read, 4 cycles active, sampled mid-cycle
task automatic read_port(input logic [15:0] addr, output logic [7:0] rdata,
	output logic hit, output logic oe);
	@(posedge fclk);
	a      <= addr;
	iorq_n <= 1'b0;
	rd_n   <= 1'b0;
	repeat (4) @(posedge fclk);
	@(negedge fclk); // away from any register update
	rdata = dout;
	hit   = porthit;
	oe    = dataout;
	@(posedge fclk);
	iorq_n <= 1'b1;
	rd_n   <= 1'b1;
endtask

`endif

/* verification/tb_zports.sv */
// testbench for the z80 i/o port block
// table of bus writes, reads and output checks, applied in one loop

`timescale 1ns/1ps

module tb_zports;

	import zport_pkg::*;

	// row operations
	localparam logic [3:0] op_wr    = 4'd0;  // bus write
	localparam logic [3:0] op_rd    = 4'd1;  // bus read, dout and dataout
	localparam logic [3:0] op_key   = 4'd2;  // fe read with random keys
	localparam logic [3:0] op_hit   = 4'd3;  // porthit during a read
	localparam logic [3:0] op_cnt   = 4'd4;  // pulse count, addr picks which
	localparam logic [3:0] op_dos   = 4'd5;  // drive dos from data bit0
	localparam logic [3:0] op_out   = 4'd6;  // direct output compare, addr picks which

	// output index for op_out rows
	localparam logic [15:0] out_rom    = 16'd0;
	localparam logic [15:0] out_p7     = 16'd1;  // gated 7ffd view
	localparam logic [15:0] out_nmi    = 16'd2;
	localparam logic [15:0] out_ena    = 16'd3;
	localparam logic [15:0] out_paddr  = 16'd4;
	localparam logic [15:0] out_pdata  = 16'd5;
	localparam logic [15:0] out_e7     = 16'd6;  // gated eff7 view
	localparam logic [15:0] out_page   = 16'd7;
	localparam logic [15:0] out_1m     = 16'd8;
	localparam logic [15:0] out_ram0   = 16'd9;
	localparam logic [15:0] out_border = 16'd10;
	localparam logic [15:0] out_romrw  = 16'd11;

	logic       fclk;
	logic       rst_n;
	logic       zpos = 1'b0;
	logic [1:0] zcnt = 2'd0;
	port_addr_t a;
	zbyte_t     din;
	logic       iorq_n, rd_n, wr_n, dos, tape_read;
	logic [4:0] keys_in;
	zbyte_t     dout, p7ffd, peff7, up_paldata;
	logic       porthit, dataout, pent1m_rom, pent1m_1m_on, pent1m_ram0_0;
	logic       romrw_en, set_nmi, clr_nmi, beeper_wr, up_ena, up_palwr;
	page_t      pent1m_page;
	border_t    border;
	up_addr_t   up_paladdr;

	logic [35:0] rows [$];  // {op, addr, data, expected}
	logic [31:0] lfsr_state;
	int          pulse_cnt [3] = '{0, 0, 0};
	string       pulse_name [3] = '{"beeper_wr", "clr_nmi", "up_palwr"};
	string       out_name [12] = '{"pent1m_rom", "p7ffd", "set_nmi", "up_ena",
		"up_paladdr", "up_paldata", "peff7", "pent1m_page", "pent1m_1m_on",
		"pent1m_ram0_0", "border", "romrw_en"};
	int          value_errs = 0;
	int          other_errs = 0;
	int          limit = 0;
	int          cycle_cnt = 0;

	`include "tb_bus_tasks.svh"

	zports_top u_dut (
		.fclk (fclk), .rst_n (rst_n), .zpos (zpos), .a (a), .din (din),
		.iorq_n (iorq_n), .rd_n (rd_n), .wr_n (wr_n), .dos (dos),
		.keys_in (keys_in), .tape_read (tape_read),
		.dout (dout), .porthit (porthit), .dataout (dataout),
		.p7ffd (p7ffd), .peff7 (peff7), .pent1m_page (pent1m_page),
		.pent1m_rom (pent1m_rom), .pent1m_1m_on (pent1m_1m_on),
		.pent1m_ram0_0 (pent1m_ram0_0), .border (border),
		.romrw_en (romrw_en), .set_nmi (set_nmi), .clr_nmi (clr_nmi),
		.beeper_wr (beeper_wr), .up_ena (up_ena), .up_paladdr (up_paladdr),
		.up_paldata (up_paldata), .up_palwr (up_palwr)
	);

	//////////////////////////////////////////////////
	// clock, zpos, monitors

	initial
	begin
		fclk = 1'b0;
		forever #5 fclk = ~fclk;
	end

	always @(posedge fclk)
	begin
		zcnt <= zcnt + 2'd1;
		zpos <= (zcnt == 2'd3); // one fclk in four
		cycle_cnt <= cycle_cnt + 1;
	end

	// strobe counters, pre-edge values
	always @(posedge fclk)
	begin
		if (rst_n === 1'b1)
		begin
			if (beeper_wr === 1'b1)
				pulse_cnt[0]++;
			if (clr_nmi === 1'b1)
				pulse_cnt[1]++;
			if (up_palwr === 1'b1)
				pulse_cnt[2]++;
		end
	end

	task automatic report_mismatch(input string name, input logic [31:0] got,
		input logic [31:0] exp);
		$display("error at %0t: %s = %0h, expected %0h", $time, name, got, exp);
		value_errs++;
	endtask

	task automatic add_row(input logic [3:0] op, input logic [15:0] addr,
		input logic [7:0] data, input logic [7:0] exp);
		rows.push_back({op, addr, data, exp});
	endtask

	task automatic random_bit(output logic b);
		b = lfsr_state[0]; // one step per bit taken
		lfsr_state = lfsr_next(lfsr_state);
	endtask

	// dut output picked by an op_out row, zero extended
	function automatic logic [7:0] out_value(input logic [3:0] idx);
		case (idx)
			4'd0:    return {7'd0, pent1m_rom};
			4'd1:    return p7ffd;
			4'd2:    return {7'd0, set_nmi};
			4'd3:    return {7'd0, up_ena};
			4'd4:    return {2'd0, up_paladdr};
			4'd5:    return up_paldata;
			4'd6:    return peff7;
			4'd7:    return {2'd0, pent1m_page};
			4'd8:    return {7'd0, pent1m_1m_on};
			4'd9:    return {7'd0, pent1m_ram0_0};
			4'd10:   return {4'd0, border};
			4'd11:   return {7'd0, romrw_en};
			default: return 8'hxx;
		endcase
	endfunction

	//////////////////////////////////////////////////
	// stimulus table

	task automatic load_table();
		// border, fe read, beeper only on fe
		add_row(op_wr, 16'h00FE, 8'h05, 8'h00);
		add_row(op_rd, {3'b000, rb_border, port_be}, 8'h00, 8'h05);
		add_row(op_wr, 16'h00F6, 8'h05, 8'h00);
		add_row(op_rd, {3'b000, rb_border, port_be}, 8'h00, 8'h0D); // f6 sets bit3
		add_row(op_out, out_border, 8'h00, 8'h0D);
		add_row(op_key, 16'h00FE, 8'h00, 8'h00);
		add_row(op_cnt, 16'h0000, 8'h00, 8'h01);
		// paging, fffd is not 7ffd
		add_row(op_wr, 16'h7FFD, 8'h17, 8'h00);
		add_row(op_rd, {3'b000, rb_7ffd, port_be}, 8'h00, 8'h17);
		add_row(op_out, out_rom, 8'h00, 8'h01);
		add_row(op_wr, 16'hFFFD, 8'h55, 8'h00);
		add_row(op_rd, {3'b000, rb_7ffd, port_be}, 8'h00, 8'h17);
		// 1M block, then 48K lock
		add_row(op_wr, 16'hEFF7, 8'h04, 8'h00);
		add_row(op_rd, {3'b000, rb_eff7, port_be}, 8'h00, 8'h04);
		add_row(op_out, out_ram0, 8'h00, 8'h00);
		add_row(op_wr, 16'h7FFD, 8'h37, 8'h00);
		add_row(op_rd, {3'b000, rb_7ffd, port_be}, 8'h00, 8'h37);
		add_row(op_out, out_page, 8'h00, 8'h0F); // 7ffd bits 7..5 over 2..0
		add_row(op_wr, 16'h7FFD, 8'h11, 8'h00); // locked, dropped
		add_row(op_rd, {3'b000, rb_7ffd, port_be}, 8'h00, 8'h37);
		add_row(op_out, out_p7, 8'h00, 8'h17); // bits 7..5 hidden
		// shadow from xxBF bit0
		add_row(op_wr, 16'h00BF, 8'h01, 8'h00);
		add_row(op_rd, 16'h00BF, 8'h00, 8'h01);
		add_row(op_wr, 16'hEFF7, 8'h00, 8'h00);
		add_row(op_rd, {3'b000, rb_eff7, port_be}, 8'h00, 8'h04);
		add_row(op_hit, 16'h00F7, 8'h00, 8'h00);
		// config and nmi
		add_row(op_wr, 16'h00BF, 8'h0A, 8'h00);
		add_row(op_rd, 16'h00BF, 8'h00, 8'h0A);
		add_row(op_out, out_nmi, 8'h00, 8'h01);
		add_row(op_out, out_romrw, 8'h00, 8'h01);
		add_row(op_hit, 16'h00F7, 8'h00, 8'h01);
		// shadow from dos
		add_row(op_dos, 16'h0000, 8'h01, 8'h00);
		add_row(op_hit, 16'h00F7, 8'h00, 8'h00);
		add_row(op_wr, 16'hEFF7, 8'h00, 8'h00);
		add_row(op_rd, {3'b000, rb_eff7, port_be}, 8'h00, 8'h04);
		add_row(op_dos, 16'h0000, 8'h00, 8'h00);
		add_row(op_wr, 16'h00BE, 8'h00, 8'h00);
		add_row(op_cnt, 16'h0001, 8'h00, 8'h01);
		// ulaplus mode, then palette
		add_row(op_wr, 16'h003B, 8'h40, 8'h00);
		add_row(op_wr, 16'h403B, 8'h01, 8'h00);
		add_row(op_out, out_ena, 8'h00, 8'h01);
		add_row(op_cnt, 16'h0002, 8'h00, 8'h00);
		add_row(op_wr, 16'h003B, 8'h05, 8'h00);
		add_row(op_wr, 16'h403B, 8'hE3, 8'h00);
		add_row(op_cnt, 16'h0002, 8'h00, 8'h01);
		add_row(op_out, out_paddr, 8'h00, 8'h05);
		add_row(op_out, out_pdata, 8'h00, 8'h1F); // E3 as R3G3B2
		add_row(op_rd, 16'h003B, 8'h00, 8'hE3);
		// eff7 views, 1M block off then on again
		add_row(op_wr, 16'hEFF7, 8'h4A, 8'h00);
		add_row(op_out, out_e7, 8'h00, 8'h4A);
		add_row(op_out, out_1m, 8'h00, 8'h01);
		add_row(op_out, out_ram0, 8'h00, 8'h01);
		add_row(op_out, out_p7, 8'h00, 8'h37); // lock gone, high bits visible
		add_row(op_wr, 16'hEFF7, 8'hCF, 8'h00);
		add_row(op_out, out_e7, 8'h00, 8'h81); // bits 6 and 3..1 hidden
		add_row(op_out, out_1m, 8'h00, 8'h00);
	endtask

	//////////////////////////////////////////////////
	// main sequence

	initial
	begin
		int          i;
		int          k;
		logic [3:0]  op;
		logic [15:0] addr;
		logic [7:0]  data, exp, rdata, got;
		logic        hit, oe, t;
		logic [4:0]  keys;

		rst_n     <= 1'b0;
		a         <= 16'h0000;
		din       <= 8'h00;
		iorq_n    <= 1'b1;
		rd_n      <= 1'b1;
		wr_n      <= 1'b1;
		dos       <= 1'b0;
		keys_in   <= 5'h1F;
		tape_read <= 1'b0;
		lfsr_state = 32'ha8f0cd5a;
		load_table();
		limit = rows.size() * 20 + 16 + 100;

		repeat (16) @(posedge fclk);
		rst_n <= 1'b1;
		repeat (2) @(posedge fclk);

		for (i = 0; i < rows.size(); i++)
		begin
			op   = rows[i][35:32];
			addr = rows[i][31:16];
			data = rows[i][15:8];
			exp  = rows[i][7:0];
			case (op)
				op_wr:
					write_port(addr, data);
				op_rd:
				begin
					read_port(addr, rdata, hit, oe);
					if (rdata !== exp)
						report_mismatch("dout", 32'(rdata), 32'(exp));
					if (oe !== 1'b1)
						report_mismatch("dataout", 32'(oe), 32'd1);
				end
				op_key:
				begin
					for (k = 0; k < 5; k++)
						random_bit(keys[k]);
					random_bit(t);
					@(posedge fclk);
					keys_in   <= keys;
					tape_read <= t;
					read_port(addr, rdata, hit, oe);
					exp = {1'b1, t, 1'b0, keys}; // fe read layout
					if (rdata !== exp)
						report_mismatch("dout", 32'(rdata), 32'(exp));
				end
				op_hit:
				begin
					read_port(addr, rdata, hit, oe);
					if (hit !== exp[0])
						report_mismatch("porthit", 32'(hit), 32'(exp[0]));
					if (oe !== exp[0])
						report_mismatch("dataout", 32'(oe), 32'(exp[0]));
				end
				op_dos:
				begin
					@(posedge fclk);
					dos <= data[0];
				end
				op_cnt:
				begin
					@(negedge fclk);
					if (pulse_cnt[addr[1:0]] != int'(exp))
						report_mismatch(pulse_name[addr[1:0]], pulse_cnt[addr[1:0]],
							32'(exp));
				end
				op_out:
				begin
					@(negedge fclk);
					got = out_value(addr[3:0]);
					if (got !== exp)
						report_mismatch(out_name[addr[3:0]], 32'(got), 32'(exp));
				end
				default:
				begin
					$display("row %0d has an unknown operation %0d", i, op);
					other_errs++;
				end
			endcase
		end

		$display("summary: %0d rows, %0d value errors, %0d other errors",
			rows.size(), value_errs, other_errs);
		if (value_errs == 0 && other_errs == 0)
			$display("Test OK");
		else
			$display("Test FAILED");
		$finish;
	end

	// watchdog on the cycle counter
	initial
	begin
		wait (limit > 0 && cycle_cnt >= limit);
		$display("timeout after %0d cycles, the table did not complete", cycle_cnt);
		$display("summary: %0d rows, %0d value errors, %0d other errors",
			rows.size(), value_errs, other_errs + 1);
		$display("Test FAILED");
		$finish;
	end

endmodule
